// ==== logic/i2si_pkg.sv ====
`default_nettype none

package i2si_pkg;

    localparam int sample_w   = 16;                 // bits per channel sample
    localparam int frame_bits = 2 * sample_w;       // sck rises per stereo frame
    localparam int val_w      = 12;                 // bist value, start and limit
    localparam int inc_w      = 8;                  // bist increment
    localparam int pad_w      = sample_w - val_w;   // zero pad above the bist value
    localparam int drop_w     = 8;                  // dropped frame counter
    localparam int bit_cnt_w  = 5;                  // counts 0..31 within a frame

    localparam logic [bit_cnt_w-1:0] last_bit = bit_cnt_w'(frame_bits - 1); // 32nd bit

    // command opcodes, 3 bits on the wire
    typedef enum logic [2:0] {
        op_nop       = 3'd0,
        op_set_start = 3'd1,
        op_set_inc   = 3'd2,
        op_set_limit = 3'd3,
        op_set_mode  = 3'd4
    } opcode_t;

    // one command word, 16 bits
    typedef struct packed {
        opcode_t          opcode;   // [15:13]
        logic             rsvd;     // [12] spare, ignored
        logic [val_w-1:0] arg;      // [11:0] value, low 8 bits for inc, bit 0 for mode
    } cmd_t;

    // settings seen by the pattern generator and output stage
    typedef struct packed {
        logic [val_w-1:0] start;    // first value of the sequence
        logic [inc_w-1:0] inc;      // step per frame
        logic [val_w-1:0] limit;    // upper bound before wrap
        logic             bist_on;  // 1 selects the counter pattern
        logic             restart;  // one-cycle reload pulse
    } bist_cfg_t;

    // one output word
    typedef struct packed {
        logic [frame_bits-1:0] data;  // left in upper half
        logic                  src;   // 1 for bist pattern
    } sample_t;

endpackage

`default_nettype wire

// ==== logic/i2si_cmd_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2si_cmd_decode (
    input  wire                     clk,
    input  wire                     rst,
    input  wire i2si_pkg::cmd_t     cmd,
    input  wire                     cmd_req,
    output logic                    cmd_ack,
    output i2si_pkg::bist_cfg_t     cfg
);

    typedef enum logic {
        idle,       // waiting for cmd_req
        wait_drop   // ack raised, waiting for cmd_req to fall
    } state_t;

    state_t state;

    logic [i2si_pkg::val_w-1:0] start_q;    // programmed start value
    logic [i2si_pkg::inc_w-1:0] inc_q;      // programmed increment
    logic [i2si_pkg::val_w-1:0] limit_q;    // programmed upper limit
    logic                       bist_on_q;  // mode, 0 = line data
    logic                       restart_q;  // reload strobe to the generator

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state     <= idle;
            cmd_ack   <= 1'b0;
            start_q   <= '0;
            inc_q     <= i2si_pkg::inc_w'(1);   // step of one out of reset
            limit_q   <= '0;
            bist_on_q <= 1'b0;                  // line mode
            restart_q <= 1'b0;
        end
        else
        begin
            restart_q <= 1'b0;                  // pulse only
            case (state)
                idle:
                begin
                    if (cmd_req)
                    begin
                        cmd_ack <= 1'b1;        // ack and apply on the same edge
                        state   <= wait_drop;
                        case (cmd.opcode)
                            i2si_pkg::op_set_start:
                            begin
                                start_q   <= cmd.arg;
                                restart_q <= 1'b1;  // sequence restarts at new start
                            end
                            i2si_pkg::op_set_inc:
                                inc_q <= cmd.arg[i2si_pkg::inc_w-1:0];
                            i2si_pkg::op_set_limit:
                                limit_q <= cmd.arg;
                            i2si_pkg::op_set_mode:
                            begin
                                bist_on_q <= cmd.arg[0];
                                restart_q <= 1'b1;  // fresh sequence on mode change
                            end
                            default: ;              // op_nop, just handshake
                        endcase
                    end
                end
                wait_drop:
                begin
                    if (!cmd_req)
                    begin
                        cmd_ack <= 1'b0;        // closes the four-phase cycle
                        state   <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_comb
    begin
        cfg.start   = start_q;
        cfg.inc     = inc_q;
        cfg.limit   = limit_q;
        cfg.bist_on = bist_on_q;
        cfg.restart = restart_q;
    end

    // ack may only rise in answer to a request seen on the previous edge
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst)
        $rose(cmd_ack) |-> $past(cmd_req))
        else $error("cmd_ack rose without cmd_req");

endmodule

`default_nettype wire

// ==== logic/i2si_deser.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2si_deser (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 sck,
    input  wire                                 ws,
    input  wire                                 sd,
    output logic                                frame_done,
    output logic [i2si_pkg::frame_bits-1:0]     frame_data
);

    logic [1:0] sck_sync;   // two-flop synchroniser, [1] is the clean copy
    logic [1:0] ws_sync;
    logic [1:0] sd_sync;
    logic       sck_d;      // last synchronised sck, for edge detect
    logic       sck_rise;   // one clk per serial clock rise
    logic       prev_ws;    // ws at previous sck rise
    logic       armed;      // inside a frame
    logic       frame_start;
    logic       frame_end;

    logic [i2si_pkg::bit_cnt_w-1:0]  bit_cnt;     // bits taken so far
    logic [i2si_pkg::frame_bits-1:0] shift;       // msb first shifter
    logic [i2si_pkg::frame_bits-1:0] shift_next;

    assign sck_rise    = sck_sync[1] & ~sck_d;
    assign frame_start = sck_rise && prev_ws && !ws_sync[1];  // ws high to low, left begins
    assign frame_end   = sck_rise && armed && !frame_start
                         && (bit_cnt == i2si_pkg::last_bit);
    assign shift_next  = {shift[i2si_pkg::frame_bits-2:0], sd_sync[1]};

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            sck_sync   <= '0;
            ws_sync    <= '0;
            sd_sync    <= '0;
            sck_d      <= 1'b0;
            prev_ws    <= 1'b0;
            armed      <= 1'b0;
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end
        else
        begin
            sck_sync   <= {sck_sync[0], sck};
            ws_sync    <= {ws_sync[0], ws};    // same delay as sck
            sd_sync    <= {sd_sync[0], sd};
            sck_d      <= sck_sync[1];
            frame_done <= frame_end;           // third clk after the external rise
            if (sck_rise)
            begin
                prev_ws <= ws_sync[1];
                if (frame_start)
                begin
                    armed   <= 1'b1;
                    bit_cnt <= i2si_pkg::bit_cnt_w'(1);  // msb already taken
                end
                else if (armed)
                begin
                    bit_cnt <= bit_cnt + 1'b1;           // wraps to 0 after bit 31
                    if (bit_cnt == i2si_pkg::last_bit)
                        armed <= 1'b0;                   // wait for next ws fall
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (sck_rise && (frame_start || armed))
            shift <= shift_next;
        if (frame_end)
            frame_data <= shift_next;          // includes the 32nd bit
    end

    // at most one finished frame per 32 serial clocks
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst)
        frame_done |=> !frame_done)
        else $error("frame_done high two cycles running");

endmodule

`default_nettype wire

// ==== logic/i2si_bist_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2si_bist_gen (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire i2si_pkg::bist_cfg_t            cfg,
    input  wire                                 frame_done,
    output logic [i2si_pkg::frame_bits-1:0]     bist_data
);

    logic [i2si_pkg::val_w-1:0] value;    // current pattern value
    logic [i2si_pkg::val_w:0]   inc_ext;  // increment widened by one bit
    logic [i2si_pkg::val_w:0]   sum;      // value + inc with carry
    logic                       wrap;     // sum is past the limit

    assign inc_ext = {{(i2si_pkg::val_w + 1 - i2si_pkg::inc_w){1'b0}}, cfg.inc};
    assign sum     = {1'b0, value} + inc_ext;
    assign wrap    = sum > {1'b0, cfg.limit};  // carry counts as past the limit

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            value <= '0;                       // matches reset start
        else if (cfg.restart)
            value <= cfg.start;                // reload wins over a frame step
        else if (frame_done)
        begin
            if (wrap)
                value <= cfg.start;            // back to start, not to zero
            else
                value <= sum[i2si_pkg::val_w-1:0];
        end
    end

    // same value in left and right, zero extended to a sample
    assign bist_data = {{i2si_pkg::pad_w{1'b0}}, value,
                        {i2si_pkg::pad_w{1'b0}}, value};

    // after a frame step the value is within the limit of that edge,
    // unless start itself sits above it
    a_within_limit: assert property (@(posedge clk) disable iff (!rst)
        (frame_done && !cfg.restart) |=>
            (value <= $past(cfg.limit)) || ($past(cfg.start) > $past(cfg.limit)))
        else $error("bist value above limit");

endmodule

`default_nettype wire

// ==== logic/i2si_out_sel.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2si_out_sel (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 frame_done,
    input  wire [i2si_pkg::frame_bits-1:0]      frame_data,
    input  wire [i2si_pkg::frame_bits-1:0]      bist_data,
    input  wire                                 bist_on,
    output i2si_pkg::sample_t                   out,
    output logic                                out_req,
    input  wire                                 out_ack,
    output logic [i2si_pkg::drop_w-1:0]         drop_cnt
);

    typedef enum logic [1:0] {
        idle,       // port free, req and ack low
        wait_ack,   // word offered
        wait_drop   // req withdrawn, waiting for ack to fall
    } state_t;

    state_t state;

    logic                            accept;    // frame goes into the holding register
    logic                            drop;      // frame lost to back-pressure
    logic [i2si_pkg::frame_bits-1:0] sel_data;

    assign accept   = frame_done && (state == idle) && !out_ack;
    assign drop     = frame_done && !accept;
    assign sel_data = bist_on ? bist_data : frame_data;  // bist value before its step

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state    <= idle;
            out_req  <= 1'b0;
            drop_cnt <= '0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (accept)
                    begin
                        out_req <= 1'b1;    // one clk after frame_done
                        state   <= wait_ack;
                    end
                end
                wait_ack:
                begin
                    if (out_ack)
                    begin
                        out_req <= 1'b0;
                        state   <= wait_drop;
                    end
                end
                wait_drop:
                    if (!out_ack)
                        state <= idle;
                default: state <= idle;
            endcase
            if (drop && !(&drop_cnt))
                drop_cnt <= drop_cnt + 1'b1;   // saturates at all ones
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            out.data <= sel_data;
            out.src  <= bist_on;
        end
    end

    // holding register must not move under an open request
    a_out_stable: assert property (@(posedge clk) disable iff (!rst)
        ($past(out_req) && out_req) |-> $stable(out))
        else $error("out changed while out_req high");

endmodule

`default_nettype wire

// ==== logic/i2si_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2si_top (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             sck,
    input  wire                             ws,
    input  wire                             sd,
    input  wire i2si_pkg::cmd_t             cmd,
    input  wire                             cmd_req,
    output wire                             cmd_ack,
    output wire i2si_pkg::sample_t          out,
    output wire                             out_req,
    input  wire                             out_ack,
    output wire [i2si_pkg::drop_w-1:0]      drop_cnt
);

    wire i2si_pkg::bist_cfg_t           cfg;          // settings from the decoder
    wire                                frame_done;   // one pulse per stereo frame
    wire [i2si_pkg::frame_bits-1:0]     frame_data;   // deserialised line word
    wire [i2si_pkg::frame_bits-1:0]     bist_data;    // counter pattern word

    i2si_cmd_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .cmd_req    (cmd_req),
        .cmd_ack    (cmd_ack),
        .cfg        (cfg)
    );

    i2si_deser u_deser (
        .clk        (clk),
        .rst        (rst),
        .sck        (sck),
        .ws         (ws),
        .sd         (sd),
        .frame_done (frame_done),
        .frame_data (frame_data)
    );

    i2si_bist_gen u_bist (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .frame_done (frame_done),
        .bist_data  (bist_data)
    );

    i2si_out_sel u_result (
        .clk        (clk),
        .rst        (rst),
        .frame_done (frame_done),
        .frame_data (frame_data),
        .bist_data  (bist_data),
        .bist_on    (cfg.bist_on),
        .out        (out),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .drop_cnt   (drop_cnt)
    );

endmodule

`default_nettype wire

// ==== test/tb_i2si.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_i2si;

    localparam int max_wait = 2000;     // clocks allowed per handshake edge
    localparam int rec_w    = 5;        // words per script record
    localparam int rec_max  = 32;

    logic              clk;
    logic              rst;
    logic              sck;
    logic              ws;
    logic              sd;
    i2si_pkg::cmd_t    cmd;
    logic              cmd_req;
    logic              cmd_ack;
    i2si_pkg::sample_t out_word;
    logic              out_req;
    logic              out_ack;
    logic [7:0]        drop_cnt;

    logic [31:0] script [0:rec_w*rec_max-1];
    integer      seed;
    int          errors      = 0;
    int          cmds_sent   = 0;
    int          words_taken = 0;
    int          ack_rises   = 0;
    int          req_rises   = 0;
    logic        ack_prev    = 1'b0;
    logic        req_prev    = 1'b0;
    logic        bist_mode;             // mode as last commanded
    logic [11:0] m_start;               // reference pattern counter
    logic [11:0] m_limit;
    logic [11:0] m_val;
    logic [7:0]  m_inc;

    i2si_top dut (
        .clk      (clk),
        .rst      (rst),
        .sck      (sck),
        .ws       (ws),
        .sd       (sd),
        .cmd      (cmd),
        .cmd_req  (cmd_req),
        .cmd_ack  (cmd_ack),
        .out      (out_word),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .drop_cnt (drop_cnt)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;          // 8 ns period
    end

    always @(negedge clk)               // edge counters for once-only checks
    begin
        ack_prev <= cmd_ack;
        req_prev <= out_req;
        if (cmd_ack && !ack_prev)
            ack_rises <= ack_rises + 1;
        if (out_req && !req_prev)
            req_rises <= req_rises + 1;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("FAIL at %0t ns: %s expected %h got %h", $time, name, exp_v, act_v);
        errors++;
    endtask

    task automatic wait_cmd_ack(input logic level);
        int n;
        n = 0;
        while (cmd_ack !== level && n < max_wait)
        begin
            @(negedge clk);
            n++;
        end
        if (cmd_ack !== level)
        begin
            $display("timeout waiting for cmd_ack to become %0d", level);
            errors++;
        end
    endtask

    task automatic wait_out_req(input logic level);
        int n;
        n = 0;
        while (out_req !== level && n < max_wait)
        begin
            @(negedge clk);
            n++;
        end
        if (out_req !== level)
        begin
            $display("timeout waiting for out_req to become %0d", level);
            errors++;
        end
    endtask

    // next value falls back to start once the sum passes the limit
    task automatic step_model();
        if (13'(m_val) + 13'(m_inc) > 13'(m_limit))
            m_val = m_start;
        else
            m_val = m_val + 12'(m_inc);
    endtask

    // one serial bit with ws and sd changing on the sck fall
    task automatic sck_cycle(input logic ws_v, input logic sd_v);
        @(negedge clk);
        sck = 1'b0;
        ws  = ws_v;
        sd  = sd_v;
        repeat (6) @(negedge clk);
        sck = 1'b1;
        repeat (5) @(negedge clk);      // sixth comes with the next bit
    endtask

    task automatic drive_frame(input logic [31:0] word);
        int i;
        for (i = 31; i >= 0; i--)
            sck_cycle(i < 16, word[i]);  // left half with ws low and msb first
        step_model();                    // counter steps on every frame
    endtask

    task automatic send_cmd(input logic [15:0] word);
        if (cmd_ack !== 1'b0)
        begin
            $display("cmd_ack was already high before a new request");
            errors++;
        end
        @(negedge clk);
        cmd     = i2si_pkg::cmd_t'(word);
        cmd_req = 1'b1;
        wait_cmd_ack(1'b1);
        @(negedge clk);
        cmd_req = 1'b0;
        wait_cmd_ack(1'b0);
        cmds_sent++;
        case (word[15:13])
            i2si_pkg::op_set_start:
            begin
                m_start = word[11:0];
                m_val   = word[11:0];
            end
            i2si_pkg::op_set_inc:   m_inc   = word[7:0];
            i2si_pkg::op_set_limit: m_limit = word[11:0];
            i2si_pkg::op_set_mode:
            begin
                bist_mode = word[0];
                m_val     = m_start;     // mode change restarts the sequence
            end
            default: ;
        endcase
    endtask

    task automatic take_word(input logic [31:0] exp_data, input logic exp_src);
        wait_out_req(1'b1);
        if (out_word.data !== exp_data)
            report_mismatch("out.data", exp_data, out_word.data);
        if (out_word.src !== exp_src)
            report_mismatch("out.src", 32'(exp_src), 32'(out_word.src));
        out_ack = 1'b1;
        wait_out_req(1'b0);
        @(negedge clk);
        out_ack = 1'b0;
        words_taken++;
    endtask

    // first frame is held and the next n are lost to back-pressure
    task automatic run_stall(input int n, input logic [31:0] first,
                             input logic [31:0] exp_data, input logic exp_src);
        logic [7:0] drops_before;
        int         i;
        drive_frame(first);
        wait_out_req(1'b1);
        drops_before = drop_cnt;
        for (i = 0; i < n; i++)
            drive_frame(32'($random(seed)));
        if (drop_cnt !== drops_before + 8'(n))
            report_mismatch("drop_cnt", 32'(drops_before + 8'(n)), 32'(drop_cnt));
        take_word(exp_data, exp_src);
    endtask

    task automatic run_bist(input int n, input logic [31:0] last_exp);
        logic [31:0] exp_word;
        int          i;
        exp_word = '0;
        for (i = 0; i < n; i++)
        begin
            exp_word = {4'h0, m_val, 4'h0, m_val};  // value in both halves
            drive_frame(32'($random(seed)));        // line data unused here
            take_word(exp_word, 1'b1);
        end
        if (out_word.data !== last_exp)             // held word of the last frame
            report_mismatch("out.data", last_exp, out_word.data);
    endtask

    initial
    begin
        int          rec;
        logic [31:0] kind;
        logic [31:0] payload;
        logic [31:0] filler;
        seed      = 32'ha45b_102e;
        rst       = 1'b0;
        sck       = 1'b0;
        ws        = 1'b1;
        sd        = 1'b0;
        cmd       = '0;
        cmd_req   = 1'b0;
        out_ack   = 1'b0;
        bist_mode = 1'b0;
        m_start   = '0;
        m_limit   = '0;
        m_inc     = 8'd1;               // reset values of the decoder
        m_val     = '0;
        $readmemh("test/i2si_testdata.txt", script);
        repeat (5) @(negedge clk);
        rst = 1'b1;
        sck_cycle(1'b1, 1'b0);          // ws high once so the first fall starts a frame
        rec = 0;
        while (rec < rec_max && script[rec*rec_w] != 0)
        begin
            kind    = script[rec*rec_w];
            payload = script[rec*rec_w+2];
            case (kind)
                1: send_cmd(payload[15:0]);
                2:
                begin
                    drive_frame(payload);
                    take_word(script[rec*rec_w+3], script[rec*rec_w+4][0]);
                    if (!bist_mode)
                    begin
                        filler = $random(seed);
                        drive_frame(filler);
                        take_word(filler, 1'b0);
                    end
                end
                3: run_stall(int'(script[rec*rec_w+1]), payload, script[rec*rec_w+3],
                             script[rec*rec_w+4][0]);
                4: run_bist(int'(script[rec*rec_w+1]), script[rec*rec_w+3]);
                default:
                begin
                    $display("unknown record kind %0h in the stimulus file", kind);
                    errors++;
                end
            endcase
            rec++;
        end
        if (script[rec*rec_w] !== 32'd0)
        begin
            $display("stimulus file did not end with an end record");
            errors++;
        end
        repeat (4) @(negedge clk);
        if (ack_rises != cmds_sent)
            report_mismatch("cmd_ack rises", 32'(cmds_sent), 32'(ack_rises));
        if (req_rises != words_taken)
            report_mismatch("out_req rises", 32'(words_taken), 32'(req_rises));
        $display("commands %0d, words %0d, errors %0d", cmds_sent, words_taken, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/i2si_pkg.sv
logic/i2si_cmd_decode.sv
logic/i2si_deser.sv
logic/i2si_bist_gen.sv
logic/i2si_out_sel.sv
logic/i2si_top.sv
test/tb_i2si.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_i2si
FILELIST  = sim.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/i2si_testdata.txt ====
// kind count payload expected src, all hex; kind 1 command, 2 frame, 3 stall, 4 bist run, 0 end
// command payload is the 16-bit cmd word, a stall drops count frames, a run ends on expected
2 00 a5a51234 a5a51234 0
2 00 0001ffff 0001ffff 0
1 00 00000000 00000000 0
3 03 c0de0042 c0de0042 0
1 00 00004001 00000000 0
1 00 00006019 00000000 0
1 00 00002001 00000000 0
1 00 00008001 00000000 0
4 1a 00000000 00010001 1
2 00 12345678 00020002 1
1 00 00004007 00000000 0
1 00 00006020 00000000 0
4 05 00000000 001f001f 1
2 00 00000000 00010001 1
1 00 00002005 00000000 0
2 00 00000000 00050005 1
2 00 00000000 000c000c 1
1 00 00008000 00000000 0
2 00 deadbeef deadbeef 0
0 00 00000000 00000000 0
